// File: hdl/drivePkg.sv
`default_nettype none

package drivePkg;

    localparam int byteW       = 8;   // Bits per UART character
    localparam int maxFrameLen = 28;  // Reverse and pivot frames
    localparam int minFrameLen = 20;  // Stop frame
    localparam int frameIndexW = 5;   // Enough for 0..27
    localparam int speedMaxLen = 5;   // Longest speed text, "-0.25"

    typedef enum logic [2:0] {
        cmdStop    = 3'd0,
        cmdLeft    = 3'd1,
        cmdRight   = 3'd2,
        cmdSlow    = 3'd3,
        cmdMedium  = 3'd4,
        cmdFast    = 3'd5,
        cmdReverse = 3'd6,
        cmdPivot   = 3'd7
    } driveCmdE;

    typedef struct packed {
        logic [byteW-1:0] data;  // ASCII character
        logic             last;  // Newline closes the frame
    } frameByteS;

    // Right-justified text, chars[len-1] is the first character sent
    typedef struct packed {
        logic [speedMaxLen-1:0][byteW-1:0] chars;
        logic [2:0]                        len;
    } speedTextS;

    function automatic speedTextS speedStr(input logic [speedMaxLen*byteW-1:0] s,
                                           input logic [2:0] n);
        speedTextS t;
        t.chars = s;
        t.len   = n;
        return t;
    endfunction

    // Wheel speed text per command, rightWheel picks the R field
    function automatic speedTextS speedText(input driveCmdE cmd, input logic rightWheel);
        speedTextS t;
        case (cmd)
            cmdStop:    t = speedStr("0", 3'd1);
            cmdLeft:    t = rightWheel ? speedStr("0.12", 3'd4) : speedStr("-0.00", 3'd5);
            cmdRight:   t = rightWheel ? speedStr("-0.00", 3'd5) : speedStr("0.12", 3'd4);
            cmdSlow:    t = speedStr("0.05", 3'd4);
            cmdMedium:  t = speedStr("0.25", 3'd4);
            cmdFast:    t = speedStr("0.5", 3'd3);
            cmdReverse: t = speedStr("-0.25", 3'd5);
            cmdPivot:   t = rightWheel ? speedStr("-0.25", 3'd5) : speedStr("-0.00", 3'd5);
            default:    t = speedStr("0", 3'd1);
        endcase
        return t;
    endfunction

endpackage

`default_nettype wire

// File: hdl/driveCommandRom.sv
`default_nettype none

module driveCommandRom
    import drivePkg::*;
(
    input  driveCmdE               cmd,
    input  logic [frameIndexW-1:0] index,
    output frameByteS              frameByte
);

    localparam int prefixLen = 11;  // {"T":1,"L":
    localparam int sepLen    = 5;   // ,"R":

    // First character sits in the highest element
    localparam logic [prefixLen-1:0][byteW-1:0] prefixText = "{\"T\":1,\"L\":";
    localparam logic [sepLen-1:0][byteW-1:0]    sepText    = ",\"R\":";

    speedTextS              leftText;
    speedTextS              rightText;
    logic [frameIndexW-1:0] sepStart;    // First separator byte
    logic [frameIndexW-1:0] rightStart;  // First right speed byte
    logic [frameIndexW-1:0] closeIdx;    // Closing brace
    logic [frameIndexW-1:0] newlineIdx;  // Final byte
    logic [frameIndexW-1:0] offset;      // Element inside current segment

    assign leftText  = speedText(cmd, 1'b0);
    assign rightText = speedText(cmd, 1'b1);

    // Segment ends from the two variable text lengths
    assign sepStart   = frameIndexW'(prefixLen) + frameIndexW'(leftText.len);
    assign rightStart = sepStart + frameIndexW'(sepLen);
    assign closeIdx   = rightStart + frameIndexW'(rightText.len);
    assign newlineIdx = closeIdx + 1'b1;

    // Element = segmentEnd - 1 - index for every right-justified segment
    always_comb begin
        offset         = '0;
        frameByte.data = '0;
        frameByte.last = 1'b0;
        if (index < frameIndexW'(prefixLen)) begin
            offset         = frameIndexW'(prefixLen - 1) - index;
            frameByte.data = prefixText[offset];
        end else if (index < sepStart) begin
            offset         = sepStart - 1'b1 - index;  // Left speed
            frameByte.data = leftText.chars[offset];
        end else if (index < rightStart) begin
            offset         = rightStart - 1'b1 - index;
            frameByte.data = sepText[offset];
        end else if (index < closeIdx) begin
            offset         = closeIdx - 1'b1 - index;  // Right speed
            frameByte.data = rightText.chars[offset];
        end else if (index == closeIdx) begin
            frameByte.data = "}";
        end else if (index == newlineIdx) begin
            frameByte.data = "\n";
            frameByte.last = 1'b1;
        end
    end

    // Sequencer index stays inside the frame
    always_comb begin
        if (!$isunknown(index)) begin
            assert (index <= frameIndexW'(maxFrameLen - 1))
                else $error("frame index %0d past end of frame", index);
        end
    end

endmodule

`default_nettype wire

// File: hdl/frameSequencer.sv
`default_nettype none

module frameSequencer
    import drivePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  driveCmdE               driveCmd,
    output driveCmdE               cmdLatched,   // Held for a whole frame
    output logic [frameIndexW-1:0] frameIndex,
    input  frameByteS              frameByte,
    output logic [byteW-1:0]       txByte,
    output logic                   txValid,
    input  logic                   txReady,
    output logic                   frameDone
);

    typedef enum logic [1:0] {
        stLatch,  // Sample command, rewind index
        stSend,   // Offer current byte
        stWait    // Byte on the line
    } seqStateE;

    seqStateE state;

    assign txByte    = frameByte.data;                       // Straight from ROM
    assign txValid   = (state == stSend) && txReady;         // Only offered when ready
    assign frameDone = (state == stWait) && txReady && frameByte.last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= stLatch;
            cmdLatched <= cmdStop;
            frameIndex <= '0;
        end else begin
            case (state)
                stLatch: begin
                    cmdLatched <= driveCmd;
                    frameIndex <= '0;
                    state      <= stSend;
                end
                stSend: begin
                    if (txValid) begin
                        state <= stWait;  // Accepted this cycle
                    end
                end
                stWait: begin
                    if (txReady) begin
                        if (frameByte.last) begin
                            state <= stLatch;  // Newline sent, next frame
                        end else begin
                            frameIndex <= frameIndex + 1'b1;
                            state      <= stSend;
                        end
                    end
                end
                default: state <= stLatch;
            endcase
        end
    end

    // Transmitter drops ready right after taking a byte
    assert property (@(posedge clk) disable iff (rst) txValid |=> !txReady)
        else $error("txReady still high after byte transfer");

endmodule

`default_nettype wire

// File: hdl/bitTimer.sv
`default_nettype none

module bitTimer #(
    parameter int clksPerBit = 434
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic bitTick
);

    localparam int cntW = $clog2(clksPerBit + 1);

    logic [cntW-1:0] count;  // Cycles left in current bit

    assign bitTick = (count == '0);  // Last cycle of the bit period

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= cntW'(clksPerBit - 1);
        end else if (restart || bitTick) begin
            count <= cntW'(clksPerBit - 1);  // Reload, next tick in clksPerBit
        end else begin
            count <= count - 1'b1;
        end
    end

    // Bit periods never shorter than clksPerBit
    assert property (@(posedge clk) disable iff (rst)
        bitTick |=> !bitTick [* (clksPerBit - 1)])
        else $error("bit ticks closer than %0d cycles", clksPerBit);

endmodule

`default_nettype wire

// File: hdl/uartTx.sv
`default_nettype none

module uartTx
    import drivePkg::*;
#(
    parameter int clksPerBit = 434
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [byteW-1:0] txByte,
    input  logic             txValid,
    output logic             txReady,
    output logic             txLine
);

    localparam int frameBits = byteW + 2;  // Start, data, stop

    logic [frameBits-1:0] shiftReg;  // LSB is on the line
    logic [3:0]           bitCount;  // Bits finished
    logic                 busy;
    logic                 accept;
    logic                 restart;
    logic                 bitTick;

    assign txReady = !busy;
    assign accept  = txValid && txReady;
    assign restart = accept;     // Align bit period to start bit
    assign txLine  = shiftReg[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            bitCount <= '0;
            shiftReg <= '1;  // Line idles high
        end else if (accept) begin
            busy     <= 1'b1;
            bitCount <= '0;
            shiftReg <= {1'b1, txByte, 1'b0};  // Stop, data LSB first, start
        end else if (busy && bitTick) begin
            shiftReg <= {1'b1, shiftReg[frameBits-1:1]};  // Backfill idle level
            bitCount <= bitCount + 1'b1;
            if (bitCount == 4'(frameBits - 1)) begin
                busy <= 1'b0;  // Stop bit done
            end
        end
    end

    bitTimer #(
        .clksPerBit(clksPerBit)
    ) timer (
        .clk    (clk),
        .rst    (rst),
        .restart(restart),
        .bitTick(bitTick)
    );

    // Idle line between bytes, shift register fully refilled with ones
    assert property (@(posedge clk) disable iff (rst) txReady |-> txLine)
        else $error("txLine low while transmitter ready");

endmodule

`default_nettype wire

// File: hdl/jsonUartTop.sv
`default_nettype none

module jsonUartTop
    import drivePkg::*;
#(
    parameter int clksPerBit = 434  // 115200 baud at 50 MHz
) (
    input  logic     clk,
    input  logic     rst,
    input  driveCmdE driveCmd,
    output logic     txLine,
    output logic     frameDone
);

    driveCmdE               cmdLatched;  // Command of frame in flight
    logic [frameIndexW-1:0] frameIndex;
    frameByteS              frameByte;
    logic [byteW-1:0]       txByte;
    logic                   txValid;
    logic                   txReady;

    frameSequencer sequencer (
        .clk       (clk),
        .rst       (rst),
        .driveCmd  (driveCmd),
        .cmdLatched(cmdLatched),
        .frameIndex(frameIndex),
        .frameByte (frameByte),
        .txByte    (txByte),
        .txValid   (txValid),
        .txReady   (txReady),
        .frameDone (frameDone)
    );

    driveCommandRom rom (
        .cmd      (cmdLatched),
        .index    (frameIndex),
        .frameByte(frameByte)
    );

    uartTx #(
        .clksPerBit(clksPerBit)
    ) tx (
        .clk    (clk),
        .rst    (rst),
        .txByte (txByte),
        .txValid(txValid),
        .txReady(txReady),
        .txLine (txLine)
    );

endmodule

`default_nettype wire

// File: sim/jsonUartTb.sv
`default_nettype none

module jsonUartTb
    import drivePkg::*;
();

    localparam int clksPerBit = 8;   // Short bit time for simulation
    localparam int numVecs    = 8;   // One vector per command
    localparam int vecWords   = 31;  // Command, frame count, length, 28 bytes
    localparam int hdrWords   = 3;

    logic     clk;
    logic     rst = 1'b1;  // Held from time zero
    driveCmdE driveCmd;
    logic     txLine;
    logic     frameDone;

    logic [7:0]  testMem [0:numVecs*vecWords-1];  // Data file image
    int          valueErrors    = 0;  // Wrong characters or lengths
    int          protocolErrors = 0;  // Framing and pulse problems
    int          framesDecoded  = 0;
    int          donePulses     = 0;
    int          totalFrames    = 0;
    int          cycleLimit     = 0;  // Set once the data file is read
    logic        expectDone     = 1'b0;  // Newline seen, pulse still owed
    logic [31:0] rngState;

    jsonUartTop #(
        .clksPerBit(clksPerBit)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .driveCmd (driveCmd),
        .txLine   (txLine),
        .frameDone(frameDone)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // Period 20
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int vecField(input int vec, input int word);
        return int'(testMem[vec*vecWords + word]);  // Word 3 on is byte 0 on
    endfunction

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual)
            else begin
                valueErrors++;
                $display("CHECK FAILED at %0t: %s expected 0x%02h actual 0x%02h",
                         $time, name, expected, actual);
            end
    endtask

    task automatic protocolError(input string what);
        protocolErrors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic reportAndFinish(input logic timedOut);
        $display("Errors %0d (value %0d, protocol %0d), frames %0d of %0d, frameDone pulses %0d",
                 valueErrors + protocolErrors, valueErrors, protocolErrors,
                 framesDecoded, totalFrames, donePulses);
        if (!timedOut && valueErrors + protocolErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // One 8N1 character, called on the first low sample of the start bit
    task automatic receiveByte(output logic [7:0] data);
        logic [9:0] bits;
        logic       first;
        logic       steady;
        int         b;
        int         c;
        for (b = 0; b < 10; b++) begin
            steady = 1'b1;
            first  = 1'b0;
            for (c = 0; c < clksPerBit; c++) begin
                if (b != 0 || c != 0) begin
                    @(negedge clk);
                end
                if (c == 0) begin
                    first = txLine;
                end else if (txLine !== first) begin
                    steady = 1'b0;  // Edge inside the bit window
                end
                if (c == clksPerBit / 2) begin
                    bits[b] = txLine;  // Mid-bit sample
                end
            end
            assert (steady)
                else protocolError($sformatf("bit %0d did not hold for %0d cycles", b, clksPerBit));
        end
        assert (bits[0] === 1'b0) else protocolError("start bit went high before mid-bit");
        assert (bits[9] === 1'b1) else protocolError("stop bit was low, framing error");
        data = bits[8:1];  // LSB first on the line
    endtask

    initial begin : stimulus
        int vec;
        int target;
        int delay;
        int totalBytes;
        rngState   = 32'h74a5;
        driveCmd   = cmdStop;
        totalBytes = 0;
        $readmemh("sim/driveTests.mem", testMem);
        driveCmd = driveCmdE'(vecField(0, 0));  // First command before reset ends
        for (vec = 0; vec < numVecs; vec++) begin
            totalFrames += vecField(vec, 1);
            totalBytes  += vecField(vec, 1) * vecField(vec, 2);
        end
        assert (totalFrames > 0) else protocolError("test data file missing or empty");
        cycleLimit = totalBytes * 10 * clksPerBit * 2 + 200;
        repeat (5) begin
            @(negedge clk);
            assert (txLine === 1'b1) else protocolError("txLine not idle high in reset");
            assert (frameDone === 1'b0) else protocolError("frameDone high in reset");
        end
        rst = 1'b0;
        @(negedge clk);
        assert (txLine === 1'b1) else protocolError("txLine not idle high after reset");
        target = 0;
        for (vec = 0; vec < numVecs - 1; vec++) begin
            target += vecField(vec, 1);
            wait (donePulses >= target - 1);  // Last frame of this vector running
            rngState = nextRandom(rngState);
            delay    = 4 + int'(rngState % 1024);  // Well short of a 1600 cycle frame
            repeat (delay) @(negedge clk);
            driveCmd = driveCmdE'(vecField(vec + 1, 0));  // Mid-frame change
        end
        wait (donePulses >= totalFrames);
        repeat (4) @(negedge clk);
        assert (framesDecoded == donePulses)
            else protocolError("decoded frame count differs from frameDone pulses");
        reportAndFinish(1'b0);
    end

    initial begin : decoder
        logic [7:0] rxByte;
        int         pos;
        int         curVec;
        int         framesInVec;
        int         expLen;
        pos         = 0;
        curVec      = 0;
        framesInVec = 0;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (txLine === 1'b0) begin
                assert (!expectDone) else protocolError("start bit came before frameDone");
                expectDone = 1'b0;
                receiveByte(rxByte);
                expLen = (curVec < numVecs) ? vecField(curVec, 2) : 0;
                if (curVec < numVecs && pos < expLen) begin
                    checkValue($sformatf("txLine frame %0d byte %0d", framesDecoded, pos),
                               vecField(curVec, hdrWords + pos), int'(rxByte));
                end
                if (rxByte == 8'h0a) begin
                    if (curVec < numVecs) begin
                        checkValue($sformatf("frame %0d length", framesDecoded),
                                   expLen, pos + 1);
                        framesInVec++;
                        if (framesInVec == vecField(curVec, 1)) begin
                            curVec++;  // Next command's frames
                            framesInVec = 0;
                        end
                    end
                    framesDecoded++;
                    pos        = 0;
                    expectDone = 1'b1;
                end else begin
                    pos++;
                end
            end
        end
    end

    initial begin : doneMonitor
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (frameDone === 1'b1) begin
                assert (expectDone) else protocolError("frameDone pulsed with no frame finished");
                expectDone = 1'b0;  // A second pulse is an error
                donePulses++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycleLimit > 0);
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d frames done",
                 cycles, donePulses, totalFrames);
        reportAndFinish(1'b1);
    end

endmodule

`default_nettype wire

// File: sim/driveTests.mem
// Per vector: command, frames to watch, frame length, then 28 frame bytes
// Frame is {"T":1,"L":<left>,"R":<right>} and a newline, unused bytes 00
// stop, L 0 R 0
00 02 14 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2c 22 52 22 3a 30 7d 0a 00 00 00 00 00 00 00 00
// left, L -0.00 R 0.12
01 02 1b 7b 22 54 22 3a 31 2c 22 4c 22 3a 2d 30 2e 30 30 2c 22 52 22 3a 30 2e 31 32 7d 0a 00
// right, L 0.12 R -0.00
02 02 1b 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 31 32 2c 22 52 22 3a 2d 30 2e 30 30 7d 0a 00
// slow, 0.05 both
03 02 1a 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 30 35 2c 22 52 22 3a 30 2e 30 35 7d 0a 00 00
// medium, 0.25 both
04 02 1a 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 32 35 2c 22 52 22 3a 30 2e 32 35 7d 0a 00 00
// fast, 0.5 both
05 02 18 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 35 2c 22 52 22 3a 30 2e 35 7d 0a 00 00 00 00
// reverse, -0.25 both
06 02 1c 7b 22 54 22 3a 31 2c 22 4c 22 3a 2d 30 2e 32 35 2c 22 52 22 3a 2d 30 2e 32 35 7d 0a
// pivot, L -0.00 R -0.25
07 02 1c 7b 22 54 22 3a 31 2c 22 4c 22 3a 2d 30 2e 30 30 2c 22 52 22 3a 2d 30 2e 32 35 7d 0a

// File: tb.f
hdl/drivePkg.sv
hdl/driveCommandRom.sv
hdl/frameSequencer.sv
hdl/bitTimer.sv
hdl/uartTx.sv
hdl/jsonUartTop.sv
sim/jsonUartTb.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module jsonUartTb -f tb.f --Mdir obj_dir

./obj_dir/VjsonUartTb > sim.log
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failure"
